// File: rtl/cap_cfg_pkg.sv
package cap_cfg_pkg;

  // -------------------------------------------------------------------------
  // sizes
  // -------------------------------------------------------------------------
  localparam int NUM_SLOTS = 2;
  localparam int SLOT_W    = $clog2(NUM_SLOTS);
  localparam int BUF_WORDS = 1024;
  localparam int BUF_AW    = $clog2(BUF_WORDS);
  localparam int DATA_W    = 16;
  localparam int LEN_W     = 12;
  localparam int TS_W      = 32;

  // -------------------------------------------------------------------------
  // address map, region code in addr[15:13], word number in addr[12:1]
  // -------------------------------------------------------------------------
  localparam logic [2:0] REGION_GLOBAL    = 3'd0;
  localparam logic [2:0] REGION_SLOT_BASE = 3'd4;
  localparam int         REG_WORDS        = 3;
  localparam int         BUF_WORD_OFS     = 4;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GAP,
    CAPTURE
  } slot_state_e;

  // bit 2 set for the slot registers, low bits are the word number
  typedef enum logic [2:0] {
    STATUS = 3'b000,
    CNT_LO = 3'b001,
    CNT_HI = 3'b010,
    TS_LO  = 3'b100,
    TS_HI  = 3'b101,
    LEN    = 3'b110
  } reg_word_e;

  typedef enum logic [1:0] {
    ZERO,
    GLOBAL_REG,
    SLOT_REG,
    SLOT_BUF
  } rsp_src_e;

endpackage

// File: rtl/cap_bus_pkg.sv
package cap_bus_pkg;

  // host register bus
  typedef struct packed {
    logic                             valid;
    logic                             we;
    logic [15:0]                      addr;
    logic [cap_cfg_pkg::DATA_W-1:0]   wdata;
    logic [1:0]                       sel;
  } host_req_t;

  typedef struct packed {
    logic                             ack;
    logic [cap_cfg_pkg::DATA_W-1:0]   rdata;
  } host_rsp_t;

  // one GMII receive port
  typedef struct packed {
    logic                             dv;
    logic [7:0]                       data;
  } gmii_rx_t;

  // -------------------------------------------------------------------------
  // decoder, slot and mux traffic
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic                             arm;
    logic                             clear_done;
  } slot_ctrl_t;

  typedef struct packed {
    logic                             armed;
    logic                             done;
    logic [cap_cfg_pkg::TS_W-1:0]     ts;
    logic [cap_cfg_pkg::LEN_W-1:0]    len;
  } slot_view_t;

  typedef struct packed {
    logic                             valid;
    logic [cap_cfg_pkg::BUF_AW-1:0]   addr;
  } buf_rd_t;

  typedef struct packed {
    logic                             valid;
    logic [cap_cfg_pkg::DATA_W-1:0]   data;
  } buf_data_t;

  typedef struct packed {
    logic                             valid;
    cap_cfg_pkg::rsp_src_e            src;
    logic [cap_cfg_pkg::SLOT_W-1:0]   slot;
    cap_cfg_pkg::reg_word_e           word;
  } rsp_cmd_t;

endpackage

// File: rtl/host_reg_decode.sv
`timescale 1ns/1ps

module host_reg_decode (
  input  logic                                                clk_125,
  input  logic                                                core_rst_n,
  input  cap_bus_pkg::host_req_t                              host_req_i,
  input  logic                                                rsp_ack_i,
  input  cap_bus_pkg::slot_view_t [cap_cfg_pkg::NUM_SLOTS-1:0] slot_view_i,
  output cap_bus_pkg::slot_ctrl_t [cap_cfg_pkg::NUM_SLOTS-1:0] slot_ctrl_o,
  output cap_bus_pkg::buf_rd_t    [cap_cfg_pkg::NUM_SLOTS-1:0] buf_rd_o,
  output cap_bus_pkg::rsp_cmd_t                               rsp_cmd_o,
  output logic [cap_cfg_pkg::TS_W-1:0]                        global_cnt_o,
  output logic [cap_cfg_pkg::DATA_W-1:0]                      status_o,
  output logic                                                irq_o
);

  logic                              busy;
  logic                              ack_q;
  logic                              accept;
  logic [2:0]                        region;
  logic [11:0]                       word;
  logic                              is_global;
  logic                              slot_hit;
  logic                              reg_hit;
  logic                              buf_hit;
  logic [cap_cfg_pkg::SLOT_W-1:0]    slot_idx;
  logic [cap_cfg_pkg::BUF_AW-1:0]    buf_addr;
  cap_cfg_pkg::rsp_src_e             src;
  cap_cfg_pkg::reg_word_e            reg_word;
  logic                              status_wr;
  logic                              cnt_wr;
  logic [4:0]                        half_lsb;
  logic [cap_cfg_pkg::TS_W-1:0]      global_cnt;
  logic [cap_cfg_pkg::TS_W-1:0]      cnt_next;
  logic [cap_cfg_pkg::NUM_SLOTS-1:0] done_bits;

  // -------------------------------------------------------------------------
  // address split and request classification
  // -------------------------------------------------------------------------
  assign region    = host_req_i.addr[15:13];
  assign word      = host_req_i.addr[12:1];
  assign accept    = host_req_i.valid && !busy;
  assign is_global = (region == cap_cfg_pkg::REGION_GLOBAL);
  assign slot_hit  = (region >= cap_cfg_pkg::REGION_SLOT_BASE) &&
                     (region < cap_cfg_pkg::REGION_SLOT_BASE + cap_cfg_pkg::NUM_SLOTS);
  assign slot_idx  = cap_cfg_pkg::SLOT_W'(region - cap_cfg_pkg::REGION_SLOT_BASE);
  assign reg_hit   = (word < cap_cfg_pkg::REG_WORDS);
  assign buf_hit   = (word >= cap_cfg_pkg::BUF_WORD_OFS) &&
                     (word < cap_cfg_pkg::BUF_WORD_OFS + cap_cfg_pkg::BUF_WORDS);
  assign buf_addr  = cap_cfg_pkg::BUF_AW'(word - cap_cfg_pkg::BUF_WORD_OFS);
  assign reg_word  = cap_cfg_pkg::reg_word_e'({slot_hit, word[1:0]});

  // writes always answer with zero data
  always_comb begin
    src = cap_cfg_pkg::ZERO;
    if (!host_req_i.we) begin
      if (is_global && reg_hit) begin
        src = cap_cfg_pkg::GLOBAL_REG;
      end else if (slot_hit && reg_hit) begin
        src = cap_cfg_pkg::SLOT_REG;
      end else if (slot_hit && buf_hit) begin
        src = cap_cfg_pkg::SLOT_BUF;
      end
    end
  end

  assign status_wr = accept && host_req_i.we && is_global && reg_hit &&
                     (reg_word == cap_cfg_pkg::STATUS);
  assign cnt_wr    = accept && host_req_i.we && is_global && reg_hit &&
                     (reg_word != cap_cfg_pkg::STATUS);

  // -------------------------------------------------------------------------
  // global counter, a write replaces the selected bytes of one half
  // -------------------------------------------------------------------------
  assign half_lsb = {word[1], 4'b0000};

  always_comb begin
    cnt_next = global_cnt + 1'b1;
    if (cnt_wr) begin
      cnt_next = global_cnt;
      if (host_req_i.sel[0]) begin
        cnt_next[half_lsb +: 8] = host_req_i.wdata[7:0];
      end
      if (host_req_i.sel[1]) begin
        cnt_next[half_lsb + 5'd8 +: 8] = host_req_i.wdata[15:8];
      end
    end
  end

  // status word and the arm / clear pulses it drives
  always_comb begin
    status_o = '0;
    for (int s = 0; s < cap_cfg_pkg::NUM_SLOTS; s++) begin
      status_o[2*s]   = slot_view_i[s].armed;
      status_o[2*s+1] = slot_view_i[s].done;
      done_bits[s]    = slot_view_i[s].done;
      slot_ctrl_o[s].arm        = status_wr && host_req_i.sel[(2*s)/8] &&
                                  host_req_i.wdata[2*s];
      slot_ctrl_o[s].clear_done = status_wr && host_req_i.sel[(2*s+1)/8] &&
                                  host_req_i.wdata[2*s+1];
    end
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      busy       <= 1'b0;
      ack_q      <= 1'b0;
      global_cnt <= '0;
      irq_o      <= 1'b0;
      rsp_cmd_o  <= '0;
      buf_rd_o   <= '0;
    end else begin
      ack_q      <= rsp_ack_i;
      global_cnt <= cnt_next;
      irq_o      <= |done_bits;
      if (accept) begin
        busy <= 1'b1;
      end else if (ack_q) begin
        busy <= 1'b0;
      end
      rsp_cmd_o <= '{valid: accept, src: src, slot: slot_idx, word: reg_word};
      for (int s = 0; s < cap_cfg_pkg::NUM_SLOTS; s++) begin
        buf_rd_o[s].valid <= accept && (src == cap_cfg_pkg::SLOT_BUF) && (slot_idx == s);
        buf_rd_o[s].addr  <= buf_addr;
      end
    end
  end

  assign global_cnt_o = global_cnt;

endmodule

// File: rtl/rx_slot.sv
`timescale 1ns/1ps

module rx_slot (
  input  logic                          clk_125,
  input  logic                          core_rst_n,
  input  cap_bus_pkg::gmii_rx_t         gmii_i,
  input  cap_bus_pkg::slot_ctrl_t       ctrl_i,
  input  logic [cap_cfg_pkg::TS_W-1:0]  ts_i,
  input  cap_bus_pkg::buf_rd_t          buf_rd_i,
  output cap_bus_pkg::slot_view_t       view_o,
  output cap_bus_pkg::buf_data_t        buf_data_o
);

  // bytes beyond this are counted only
  localparam int STORE_BYTES = 2 * cap_cfg_pkg::BUF_WORDS;

  cap_cfg_pkg::slot_state_e         state;
  logic [cap_cfg_pkg::LEN_W-1:0]    byte_cnt;
  logic [cap_cfg_pkg::LEN_W-1:0]    len_q;
  logic [cap_cfg_pkg::TS_W-1:0]     ts_q;
  logic                             armed;
  logic                             done;
  logic                             byte_en;
  logic                             first_byte;
  logic [cap_cfg_pkg::BUF_AW-1:0]   wr_addr;

  logic [cap_cfg_pkg::DATA_W-1:0]   mem [cap_cfg_pkg::BUF_WORDS];
  logic [cap_cfg_pkg::DATA_W-1:0]   rd_data;
  logic                             rd_valid;

  assign first_byte = (state == cap_cfg_pkg::CAPTURE) && gmii_i.dv && (byte_cnt == '0);
  assign byte_en    = (state == cap_cfg_pkg::CAPTURE) && gmii_i.dv &&
                      (byte_cnt < STORE_BYTES);
  assign wr_addr    = byte_cnt[cap_cfg_pkg::BUF_AW:1];

  // -------------------------------------------------------------------------
  // capture FSM
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state    <= cap_cfg_pkg::IDLE;
      byte_cnt <= '0;
      len_q    <= '0;
      armed    <= 1'b0;
      done     <= 1'b0;
    end else begin
      if (ctrl_i.clear_done) begin
        done <= 1'b0;
      end
      case (state)
        cap_cfg_pkg::IDLE: begin
          if (ctrl_i.arm) begin
            state <= cap_cfg_pkg::WAIT_GAP;
            armed <= 1'b1;
            done  <= 1'b0;
          end
        end
        // a frame already on the line is skipped
        cap_cfg_pkg::WAIT_GAP: begin
          if (!gmii_i.dv) begin
            state    <= cap_cfg_pkg::CAPTURE;
            byte_cnt <= '0;
          end
        end
        cap_cfg_pkg::CAPTURE: begin
          if (gmii_i.dv) begin
            byte_cnt <= byte_cnt + 1'b1;
          end else if (byte_cnt != '0) begin
            len_q <= byte_cnt;
            done  <= 1'b1;
            armed <= 1'b0;
            state <= cap_cfg_pkg::IDLE;
          end
        end
        default: begin
          state <= cap_cfg_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_125) begin
    if (first_byte) begin
      ts_q <= ts_i;
    end
  end

  // -------------------------------------------------------------------------
  // buffer RAM, even byte fills the low lane and zeroes the high lane
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (byte_en) begin
      if (!byte_cnt[0]) begin
        mem[wr_addr] <= {8'h00, gmii_i.data};
      end else begin
        mem[wr_addr][15:8] <= gmii_i.data;
      end
    end
    rd_data <= mem[buf_rd_i.addr];
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= buf_rd_i.valid;
    end
  end

  assign view_o     = '{armed: armed, done: done, ts: ts_q, len: len_q};
  assign buf_data_o = '{valid: rd_valid, data: rd_data};

endmodule

// File: rtl/read_return_mux.sv
`timescale 1ns/1ps

module read_return_mux (
  input  logic                                                 clk_125,
  input  logic                                                 core_rst_n,
  input  cap_bus_pkg::rsp_cmd_t                                rsp_cmd_i,
  input  logic [cap_cfg_pkg::TS_W-1:0]                         global_cnt_i,
  input  logic [cap_cfg_pkg::DATA_W-1:0]                       status_i,
  input  cap_bus_pkg::slot_view_t  [cap_cfg_pkg::NUM_SLOTS-1:0] slot_view_i,
  input  cap_bus_pkg::buf_data_t   [cap_cfg_pkg::NUM_SLOTS-1:0] buf_data_i,
  output cap_bus_pkg::host_rsp_t                               host_rsp_o
);

  logic                             pend_valid;
  logic [cap_cfg_pkg::SLOT_W-1:0]   pend_slot;
  logic                             buf_ready;
  logic                             ack_q;
  logic [cap_cfg_pkg::DATA_W-1:0]   rdata_q;
  logic [cap_cfg_pkg::DATA_W-1:0]   reg_rdata;
  cap_bus_pkg::slot_view_t          view_sel;

  assign view_sel  = slot_view_i[rsp_cmd_i.slot];
  assign buf_ready = pend_valid && buf_data_i[pend_slot].valid;

  // register field select, unmapped words read zero
  always_comb begin
    reg_rdata = '0;
    case (rsp_cmd_i.src)
      cap_cfg_pkg::GLOBAL_REG: begin
        case (rsp_cmd_i.word)
          cap_cfg_pkg::STATUS: reg_rdata = status_i;
          cap_cfg_pkg::CNT_LO: reg_rdata = global_cnt_i[15:0];
          cap_cfg_pkg::CNT_HI: reg_rdata = global_cnt_i[31:16];
          default:             reg_rdata = '0;
        endcase
      end
      cap_cfg_pkg::SLOT_REG: begin
        case (rsp_cmd_i.word)
          cap_cfg_pkg::TS_LO: reg_rdata = view_sel.ts[15:0];
          cap_cfg_pkg::TS_HI: reg_rdata = view_sel.ts[31:16];
          cap_cfg_pkg::LEN:   reg_rdata = cap_cfg_pkg::DATA_W'(view_sel.len);
          default:            reg_rdata = '0;
        endcase
      end
      default: reg_rdata = '0;
    endcase
  end

  // -------------------------------------------------------------------------
  // one ack per command, buffer reads wait for the slot RAM
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      ack_q      <= 1'b0;
      pend_valid <= 1'b0;
      pend_slot  <= '0;
    end else begin
      ack_q <= 1'b0;
      if (rsp_cmd_i.valid) begin
        if (rsp_cmd_i.src == cap_cfg_pkg::SLOT_BUF) begin
          pend_valid <= 1'b1;
          pend_slot  <= rsp_cmd_i.slot;
        end else begin
          ack_q <= 1'b1;
        end
      end else if (buf_ready) begin
        ack_q      <= 1'b1;
        pend_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_125) begin
    if (rsp_cmd_i.valid) begin
      rdata_q <= reg_rdata;
    end else if (buf_ready) begin
      rdata_q <= buf_data_i[pend_slot].data;
    end
  end

  assign host_rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

// File: rtl/frame_capture_top.sv
`timescale 1ns/1ps

module frame_capture_top (
  input  logic                                              clk_125,
  input  logic                                              core_rst_n,
  input  cap_bus_pkg::host_req_t                            host_req_i,
  output cap_bus_pkg::host_rsp_t                            host_rsp_o,
  input  cap_bus_pkg::gmii_rx_t [cap_cfg_pkg::NUM_SLOTS-1:0] gmii_rx_i,
  output logic                                              irq_o
);

  cap_bus_pkg::slot_view_t  [cap_cfg_pkg::NUM_SLOTS-1:0] slot_view;
  cap_bus_pkg::slot_ctrl_t  [cap_cfg_pkg::NUM_SLOTS-1:0] slot_ctrl;
  cap_bus_pkg::buf_rd_t     [cap_cfg_pkg::NUM_SLOTS-1:0] buf_rd;
  cap_bus_pkg::buf_data_t   [cap_cfg_pkg::NUM_SLOTS-1:0] buf_data;
  cap_bus_pkg::rsp_cmd_t                                 rsp_cmd;
  logic [cap_cfg_pkg::TS_W-1:0]                          global_cnt;
  logic [cap_cfg_pkg::DATA_W-1:0]                        status;

  host_reg_decode host_reg_decode_i (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .host_req_i   (host_req_i),
    .rsp_ack_i    (host_rsp_o.ack),
    .slot_view_i  (slot_view),
    .slot_ctrl_o  (slot_ctrl),
    .buf_rd_o     (buf_rd),
    .rsp_cmd_o    (rsp_cmd),
    .global_cnt_o (global_cnt),
    .status_o     (status),
    .irq_o        (irq_o)
  );

  // -------------------------------------------------------------------------
  // capture slots, one per receive port
  // -------------------------------------------------------------------------
  for (genvar s = 0; s < cap_cfg_pkg::NUM_SLOTS; s++) begin : g_slot
    rx_slot rx_slot_i (
      .clk_125    (clk_125),
      .core_rst_n (core_rst_n),
      .gmii_i     (gmii_rx_i[s]),
      .ctrl_i     (slot_ctrl[s]),
      .ts_i       (global_cnt),
      .buf_rd_i   (buf_rd[s]),
      .view_o     (slot_view[s]),
      .buf_data_o (buf_data[s])
    );
  end

  read_return_mux read_return_mux_i (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .rsp_cmd_i    (rsp_cmd),
    .global_cnt_i (global_cnt),
    .status_i     (status),
    .slot_view_i  (slot_view),
    .buf_data_i   (buf_data),
    .host_rsp_o   (host_rsp_o)
  );

endmodule

// File: test/tb_capture_model.svh
`ifndef TB_CAPTURE_MODEL_SVH
`define TB_CAPTURE_MODEL_SVH

// word numbers inside the global and slot regions
localparam int W_STATUS = 0;
localparam int W_CNT_LO = 1;
localparam int W_CNT_HI = 2;
localparam int W_TS_LO  = 0;
localparam int W_TS_HI  = 1;
localparam int W_LEN    = 2;

// bytes last sent on each port
logic [7:0] frame_mem [cap_cfg_pkg::NUM_SLOTS][2*cap_cfg_pkg::BUF_WORDS];
int         frame_len [cap_cfg_pkg::NUM_SLOTS];

function automatic logic [15:0] global_addr(input int word);
  return {cap_cfg_pkg::REGION_GLOBAL, 12'(word), 1'b0};
endfunction

function automatic logic [15:0] slot_reg_addr(input int slot, input int word);
  logic [2:0] region;
  region = cap_cfg_pkg::REGION_SLOT_BASE + 3'(slot);
  return {region, 12'(word), 1'b0};
endfunction

function automatic logic [15:0] buf_word_addr(input int slot, input int idx);
  return slot_reg_addr(slot, cap_cfg_pkg::BUF_WORD_OFS + idx);
endfunction

// first byte low, odd tail leaves the high half zero
function automatic logic [15:0] expected_word(input int slot, input int idx);
  logic [7:0] lo;
  logic [7:0] hi;
  lo = frame_mem[slot][2*idx];
  hi = (2*idx + 1 < frame_len[slot]) ? frame_mem[slot][2*idx+1] : 8'h00;
  return {hi, lo};
endfunction

function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] wdata,
                                            input logic [1:0] sel);
  logic [15:0] res;
  res = old;
  if (sel[0]) res[7:0] = wdata[7:0];
  if (sel[1]) res[15:8] = wdata[15:8];
  return res;
endfunction

`endif

// File: test/tb_frame_capture.sv
`timescale 1ns/1ps

module tb_frame_capture;

  logic                                               clk_125;
  logic                                               core_rst_n;
  cap_bus_pkg::host_req_t                             host_req;
  cap_bus_pkg::host_rsp_t                             host_rsp;
  cap_bus_pkg::gmii_rx_t [cap_cfg_pkg::NUM_SLOTS-1:0] gmii_rx;
  logic                                               irq;
  int test_errs;
  int total_errs;
  int tests_run;
  int tests_failed;

  `include "tb_capture_model.svh"

  frame_capture_top frame_capture_top_i (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .gmii_rx_i  (gmii_rx),
    .irq_o      (irq)
  );

  initial begin
    clk_125 = 1'b0;
    forever #2 clk_125 = ~clk_125;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %s got %h expected %h", name, got, exp);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_errs);
    end else begin
      $display("test %s: ok", name);
    end
    test_errs = 0;
  endtask

  // --------------------------------------------------------------------------
  // host bus, one request at a time
  // --------------------------------------------------------------------------
  task automatic host_access(input logic we, input logic [15:0] addr, input logic [15:0] wdata,
                             input logic [1:0] sel, output logic [15:0] rdata);
    int waited;
    waited = 0;
    rdata = '0;
    @(posedge clk_125);
    host_req <= '{valid: 1'b1, we: we, addr: addr, wdata: wdata, sel: sel};
    @(negedge clk_125);
    while (!host_rsp.ack && waited < 50) begin
      @(negedge clk_125);
      waited++;
    end
    if (!host_rsp.ack) begin
      abort_run($sformatf("bus access to address %h got no ack", addr));
    end else begin
      rdata = host_rsp.rdata;
      @(posedge clk_125);
      host_req <= '0;
    end
  endtask

  task automatic host_write(input logic [15:0] addr, input logic [15:0] wdata,
                            input logic [1:0] sel);
    logic [15:0] unused;
    host_access(1'b1, addr, wdata, sel, unused);
  endtask

  task automatic host_read(input logic [15:0] addr, output logic [15:0] rdata);
    host_access(1'b0, addr, 16'h0000, 2'b11, rdata);
  endtask

  // hi, lo, hi so a carry between the halves is caught
  task automatic read_counter(output logic [31:0] value);
    logic [15:0] hi1;
    logic [15:0] hi2;
    logic [15:0] lo;
    host_read(global_addr(W_CNT_HI), hi1);
    host_read(global_addr(W_CNT_LO), lo);
    host_read(global_addr(W_CNT_HI), hi2);
    if (hi1 != hi2) host_read(global_addr(W_CNT_LO), lo);
    value = {hi2, lo};
  endtask

  task automatic wait_done(input logic [15:0] mask);
    logic [15:0] st;
    int polls;
    st = '0;
    polls = 0;
    while ((st & mask) != mask && polls < 40) begin
      host_read(global_addr(W_STATUS), st);
      polls++;
    end
    if ((st & mask) != mask) begin
      abort_run($sformatf("done bits %h never set, last status %h", mask, st));
    end
  endtask

  // --------------------------------------------------------------------------
  // GMII side
  // --------------------------------------------------------------------------
  task automatic fill_frame(input int slot, input int n);
    frame_len[slot] = n;
    for (int i = 0; i < n; i++) begin
      frame_mem[slot][i] = 8'($urandom);
    end
  endtask

  task automatic send_frame(input int port, input int gap);
    repeat (gap) begin
      @(posedge clk_125);
      gmii_rx[port] <= '0;
    end
    for (int i = 0; i < frame_len[port]; i++) begin
      @(posedge clk_125);
      gmii_rx[port] <= '{dv: 1'b1, data: frame_mem[port][i]};
    end
    @(posedge clk_125);
    gmii_rx[port] <= '0;
  endtask

  task automatic check_frame(input int slot);
    logic [15:0] rd;
    host_read(slot_reg_addr(slot, W_LEN), rd);
    if (rd !== 16'(frame_len[slot])) begin
      report_mismatch($sformatf("len slot %0d", slot), rd, frame_len[slot]);
    end
    for (int i = 0; i < (frame_len[slot] + 1) / 2; i++) begin
      host_read(buf_word_addr(slot, i), rd);
      if (rd !== expected_word(slot, i)) begin
        report_mismatch($sformatf("buf word %0d slot %0d", i, slot), rd, expected_word(slot, i));
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  initial begin
    logic [15:0] rd;
    logic [15:0] rd2;
    logic [15:0] v;
    logic [15:0] exp_hi;
    logic [31:0] t0;
    logic [31:0] t1;
    int g0;
    int g1;

    host_req     = '0;
    gmii_rx      = '0;
    core_rst_n   = 1'b0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(2));
    repeat (8) @(posedge clk_125);
    core_rst_n <= 1'b1;
    @(posedge clk_125);

    host_read(global_addr(W_STATUS), rd);
    if (rd !== 16'h0000) report_mismatch("status", rd, 0);
    if (irq !== 1'b0) report_mismatch("irq_o", irq, 0);
    host_read(global_addr(W_CNT_LO), rd);
    host_read(global_addr(W_CNT_LO), rd2);
    if (rd2 <= rd) begin
      $display("FAIL cnt_lo got %h after %h, no increase", rd2, rd);
      test_errs++;
    end
    finish_test("reset_state");

    v = 16'($urandom);
    host_write(global_addr(W_CNT_LO), 16'h0000, 2'b11);
    host_write(global_addr(W_CNT_HI), v, 2'b11);
    exp_hi = merge_lanes(16'h0000, v, 2'b11);
    v = 16'($urandom);
    host_write(global_addr(W_CNT_HI), v, 2'b10);
    exp_hi = merge_lanes(exp_hi, v, 2'b10);
    host_read(global_addr(W_CNT_HI), rd);
    if (rd !== exp_hi) report_mismatch("cnt_hi", rd, exp_hi);
    finish_test("counter_lanes");

    // odd length on purpose
    fill_frame(0, 1 + 2 * ($urandom % 750));
    host_write(global_addr(W_STATUS), 16'h0001, 2'b01);
    host_read(global_addr(W_STATUS), rd);
    if (rd !== 16'h0001) report_mismatch("status", rd, 16'h0001);
    send_frame(0, 1 + $urandom % 8);
    wait_done(16'h0002);
    if (irq !== 1'b1) report_mismatch("irq_o", irq, 1);
    check_frame(0);
    finish_test("single_capture");

    fill_frame(1, 1 + $urandom % 1500);
    read_counter(t0);
    host_write(global_addr(W_STATUS), 16'h0004, 2'b01);
    send_frame(1, 1 + $urandom % 8);
    wait_done(16'h0008);
    read_counter(t1);
    host_read(slot_reg_addr(1, W_TS_LO), rd);
    host_read(slot_reg_addr(1, W_TS_HI), rd2);
    if (!({rd2, rd} > t0 && {rd2, rd} < t1)) begin
      $display("FAIL ts slot 1 got %h, counter reads %h and %h", {rd2, rd}, t0, t1);
      test_errs++;
    end
    finish_test("timestamp");

    host_write(global_addr(W_STATUS), 16'h000A, 2'b01);
    fill_frame(0, 1 + $urandom % 300);
    send_frame(0, 1 + $urandom % 8);
    host_read(global_addr(W_STATUS), rd);
    if (rd !== 16'h0000) report_mismatch("status", rd, 0);
    // arm lands while the first frame is still on the line
    fill_frame(0, 300 + $urandom % 200);
    fork
      send_frame(0, 2);
      begin
        repeat (20) @(posedge clk_125);
        host_write(global_addr(W_STATUS), 16'h0001, 2'b01);
      end
    join
    fill_frame(0, 1 + $urandom % 200);
    send_frame(0, 1 + $urandom % 8);
    wait_done(16'h0002);
    check_frame(0);
    host_write(global_addr(W_STATUS), 16'h0002, 2'b01);
    host_read(global_addr(W_STATUS), rd);
    if (rd !== 16'h0000) report_mismatch("status", rd, 0);
    if (irq !== 1'b0) report_mismatch("irq_o", irq, 0);
    finish_test("arming_rules");

    fill_frame(0, 1 + $urandom % 1500);
    fill_frame(1, 1 + $urandom % 1500);
    g0 = 1 + $urandom % 8;
    g1 = 1 + $urandom % 8;
    host_write(global_addr(W_STATUS), 16'h0005, 2'b01);
    fork
      send_frame(0, g0);
      send_frame(1, g1);
    join
    wait_done(16'h000A);
    check_frame(0);
    check_frame(1);
    host_read(16'h4000, rd);
    if (rd !== 16'h0000) report_mismatch("rdata unmapped 4000", rd, 0);
    host_read(16'hE002, rd);
    if (rd !== 16'h0000) report_mismatch("rdata unmapped e002", rd, 0);
    finish_test("dual_port");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+test
rtl/cap_cfg_pkg.sv
rtl/cap_bus_pkg.sv
rtl/host_reg_decode.sv
rtl/rx_slot.sv
rtl/read_return_mux.sv
rtl/frame_capture_top.sv
test/tb_frame_capture.sv

// File: run.sh
#!/bin/sh
# build the frame capture testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_frame_capture -f flist.f \
  -o sim_frame_capture > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_frame_capture > sim.log 2>&1
cat sim.log
grep -qx "TEST PASS" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
